// File: flist.f
hw/dacfifo_pkg.sv
hw/dacfifo_rd_if.sv
hw/dacfifo_wr.sv
hw/dacfifo_bram.sv
hw/dacfifo_rd.sv
hw/dacfifo_top.sv
tb/tb_clk_gen.sv
tb/tb_dacfifo.sv

// File: hw/dacfifo_bram.sv
// on-chip sample memory
// written word by word from the DMA side, read back as fixed
// 4-beat bursts through the read address/read data slave port

`timescale 1ns/1ps

module dacfifo_bram
  import dacfifo_pkg::*;
(
  input  logic  axi_clk,
  input  logic  axi_resetn,

  // word write port
  input  logic  wr_en,
  input  widx_t wr_addr,
  input  word_t wr_data,

  // burst read port
  dacfifo_rd_if.slave rd
);

  word_t mem [mem_words];

  logic  active;
  beat_t beat;
  widx_t rptr;
  widx_t aidx;
  logic  ar_acc;
  logic  r_acc;

  // ************************************************************
  // write port
  // ************************************************************

  always_ff @(posedge axi_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ************************************************************
  // burst read
  // ************************************************************

  // one burst at a time
  assign rd.arready = ~active;
  assign rd.rvalid  = active;
  assign rd.rlast   = active & (beat == last_beat);

  assign ar_acc = rd.arvalid & rd.arready;
  assign r_acc  = rd.rvalid & rd.rready;
  // byte address to word index
  assign aidx   = widx_t'((rd.araddr - base_addr) >> byte_shift);

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      active <= 1'b0;
      beat   <= '0;
    end else begin
      if (ar_acc) begin
        active <= 1'b1;
        beat   <= '0;
      end else if (r_acc) begin
        beat <= beat + 1'b1;
        if (rd.rlast) begin
          active <= 1'b0;
        end
      end
    end
  end

  // registered read, next word is fetched as each beat leaves
  always_ff @(posedge axi_clk) begin
    if (ar_acc) begin
      rd.rdata <= mem[aidx];
      rptr     <= aidx + 1'b1;
    end else if (r_acc && !rd.rlast) begin
      rd.rdata <= mem[rptr];
      rptr     <= rptr + 1'b1;
    end
  end

  // requests are whole, aligned bursts of the fixed length
  a_ar_aligned: assert property (
    @(posedge axi_clk) disable iff (!axi_resetn)
    ar_acc |-> ((rd.araddr[burst_shift+byte_shift-1:0] == '0) && (rd.arlen == burst_arlen))
  );

endmodule

// File: hw/dacfifo_pkg.sv
// shared definitions for the DAC replay buffer
// sample width, burst geometry, memory depth and the address types
// used by the writer, the burst memory and the read engine

package dacfifo_pkg;

  // ************************************************************
  // sample beat
  // ************************************************************

  localparam int data_width = 32;
  localparam int byte_width = data_width / 8;

  typedef logic [data_width-1:0] word_t;

  // ************************************************************
  // burst geometry
  // ************************************************************

  // beats per read burst, the length field carries one less
  localparam int burst_len   = 4;
  localparam int burst_shift = $clog2(burst_len);
  localparam int byte_shift  = $clog2(byte_width);
  // byte distance between two burst bases
  localparam int burst_incr  = burst_len * byte_width;

  typedef logic [7:0]             len_t;
  typedef logic [burst_shift-1:0] beat_t;
  // valid beats in the final burst, 1 to burst_len
  typedef logic [2:0]             beats_t;

  localparam len_t  burst_arlen = len_t'(burst_len - 1);
  localparam beat_t last_beat   = beat_t'(burst_len - 1);

  // ************************************************************
  // memory and addressing
  // ************************************************************

  // 64 beats, so at most 16 bursts of pattern
  localparam int mem_words = 64;
  localparam int widx_w    = $clog2(mem_words);

  typedef logic [31:0]       addr_t;
  typedef logic [widx_w-1:0] widx_t;

  // pattern starts at the bottom of the memory
  localparam addr_t base_addr = 32'h0000_0000;

endpackage

// File: hw/dacfifo_rd.sv
// cyclic burst read engine
// replays the stored pattern without end once xfer_req is up,
// wraps after the final burst and trims its unused beats,
// and presents the samples on a valid/ready stream to the DAC

`timescale 1ns/1ps

module dacfifo_rd
  import dacfifo_pkg::*;
(
  input  logic   axi_clk,
  input  logic   axi_resetn,

  // handoff from the write side
  input  logic   xfer_req,
  input  addr_t  last_raddr,
  input  beats_t last_beats,

  // burst read master
  dacfifo_rd_if.master rd,

  // DAC stream
  output logic   dac_valid,
  output word_t  dac_data,
  input  logic   dac_ready,
  output logic   dac_last
);

  logic   rnext;
  logic   ractive;
  addr_t  araddr_prev;
  beats_t beat_cntr;

  logic   ready_s;
  logic   final_s;
  beats_t last_beats_s;
  logic   dvalid_s;

  // ************************************************************
  // burst request control
  // ************************************************************

  // no address pending and the DAC side can take more
  assign ready_s = (~rd.arvalid | rd.arready) & dac_ready;

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      rnext   <= 1'b0;
      ractive <= 1'b0;
    end else begin
      if (ractive) begin
        rnext <= 1'b0;
        // burst over once its last beat shows up
        if (rd.rvalid && rd.rlast) begin
          ractive <= 1'b0;
        end
      end else if (ready_s) begin
        // arm a request, single cycle pulse into the address logic
        rnext   <= xfer_req;
        ractive <= xfer_req;
      end
    end
  end

  // beat position inside the current burst
  always_ff @(posedge axi_clk) begin
    if (!axi_resetn || !xfer_req) begin
      beat_cntr <= '0;
    end else if (rd.rvalid && rd.rready) begin
      beat_cntr <= rd.rlast ? '0 : beat_cntr + 1'b1;
    end
  end

  // ************************************************************
  // address channel
  // ************************************************************

  assign rd.arlen = burst_arlen;

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      rd.arvalid  <= 1'b0;
      rd.araddr   <= base_addr;
      araddr_prev <= base_addr;
    end else begin
      if (rd.arvalid) begin
        if (rd.arready) begin
          rd.arvalid <= 1'b0;
        end
      end else if (rnext) begin
        rd.arvalid <= 1'b1;
      end
      // step to the next burst, back to the base after the final one
      if (xfer_req && rd.arvalid && rd.arready) begin
        rd.araddr   <= (rd.araddr >= last_raddr) ? base_addr :
                       rd.araddr + addr_t'(burst_incr);
        araddr_prev <= rd.araddr;
      end
    end
  end

  // ************************************************************
  // data channel
  // ************************************************************

  // data in flight belongs to the burst issued last
  assign final_s      = (araddr_prev == last_raddr);
  assign last_beats_s = last_beats - 1'b1;
  // padding beats of the final burst are dropped
  assign dvalid_s     = (final_s && (beat_cntr > last_beats_s)) ? 1'b0 :
                        (rd.rvalid & rd.rready);

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      rd.rready <= 1'b0;
      dac_valid <= 1'b0;
      dac_last  <= 1'b0;
    end else begin
      dac_valid <= dvalid_s;
      dac_last  <= final_s;
      // take each beat one cycle after it appears
      if (xfer_req) begin
        rd.rready <= rd.rvalid;
      end
    end
  end

  always_ff @(posedge axi_clk) begin
    dac_data <= rd.rdata;
  end

  // no new request while the previous burst is still streaming
  a_ar_after_burst: assert property (
    @(posedge axi_clk) disable iff (!axi_resetn)
    rd.arvalid |-> !rd.rvalid
  );

endmodule

// File: hw/dacfifo_rd_if.sv
// read address and read data channels between the read engine
// and the burst memory, the engine takes the master side

`timescale 1ns/1ps

interface dacfifo_rd_if
  import dacfifo_pkg::*;
();

  // read address channel
  logic  arvalid;
  addr_t araddr;
  len_t  arlen;
  logic  arready;

  // read data channel
  logic  rvalid;
  word_t rdata;
  logic  rlast;
  logic  rready;

  modport master (
    output arvalid, araddr, arlen, rready,
    input  arready, rvalid, rdata, rlast
  );

  modport slave (
    input  arvalid, araddr, arlen, rready,
    output arready, rvalid, rdata, rlast
  );

endinterface

// File: hw/dacfifo_top.sv
// top level of the DAC replay buffer
// DMA stream in, looping sample stream out to the DAC,
// the writer fills the burst memory and the read engine replays it

`timescale 1ns/1ps

module dacfifo_top
  import dacfifo_pkg::*;
(
  input  logic  axi_clk,
  input  logic  axi_resetn,

  // dma source
  input  logic  dma_valid,
  input  word_t dma_data,
  input  logic  dma_last,
  output logic  dma_ready,

  // DAC stream
  output logic  dac_valid,
  output word_t dac_data,
  input  logic  dac_ready,
  output logic  dac_last
);

  // memory write port
  logic   wr_en;
  widx_t  wr_addr;
  word_t  wr_data;

  // writer to reader handoff
  logic   xfer_req;
  addr_t  last_raddr;
  beats_t last_beats;

  dacfifo_rd_if rd_if ();

  dacfifo_wr i_wr (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .dma_valid  (dma_valid),
    .dma_data   (dma_data),
    .dma_last   (dma_last),
    .dma_ready  (dma_ready),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .xfer_req   (xfer_req),
    .last_raddr (last_raddr),
    .last_beats (last_beats)
  );

  dacfifo_bram i_bram (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .rd         (rd_if.slave)
  );

  dacfifo_rd i_rd (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .xfer_req   (xfer_req),
    .last_raddr (last_raddr),
    .last_beats (last_beats),
    .rd         (rd_if.master),
    .dac_valid  (dac_valid),
    .dac_data   (dac_data),
    .dac_ready  (dac_ready),
    .dac_last   (dac_last)
  );

endmodule

// File: hw/dacfifo_wr.sv
// write side of the replay buffer
// takes the DMA stream after reset and writes one word per beat,
// then hands the final burst base and beat count to the read engine

`timescale 1ns/1ps

module dacfifo_wr
  import dacfifo_pkg::*;
(
  input  logic   axi_clk,
  input  logic   axi_resetn,

  // dma source
  input  logic   dma_valid,
  input  word_t  dma_data,
  input  logic   dma_last,
  output logic   dma_ready,

  // memory write port
  output logic   wr_en,
  output widx_t  wr_addr,
  output word_t  wr_data,

  // read engine handoff
  output logic   xfer_req,
  output addr_t  last_raddr,
  output beats_t last_beats
);

  // one bit wider than the word index so a full memory is visible
  logic [widx_w:0] wcnt;
  widx_t           widx;
  widx_t           burst_word;
  logic            dma_acc;

  assign dma_acc = dma_valid & dma_ready;

  // index of the current beat and the base word of its burst
  assign widx       = wcnt[widx_w-1:0];
  assign burst_word = {widx[widx_w-1:burst_shift], {burst_shift{1'b0}}};

  // ************************************************************
  // control
  // ************************************************************

  always_ff @(posedge axi_clk) begin
    if (!axi_resetn) begin
      dma_ready <= 1'b1;
      wr_en     <= 1'b0;
      xfer_req  <= 1'b0;
      wcnt      <= '0;
    end else begin
      // write strobe trails the accepted beat by one cycle
      wr_en <= dma_acc;
      if (dma_acc) begin
        wcnt <= wcnt + 1'b1;
        // final beat, stop the source and start the replay
        if (dma_last) begin
          dma_ready <= 1'b0;
          xfer_req  <= 1'b1;
        end
      end
    end
  end

  // ************************************************************
  // write data and handoff values
  // ************************************************************

  always_ff @(posedge axi_clk) begin
    wr_addr <= widx;
    wr_data <= dma_data;
    // captured with the last beat, so stable once xfer_req is up
    if (dma_acc && dma_last) begin
      last_raddr <= base_addr + (addr_t'(burst_word) << byte_shift);
      // low index bits give the position inside the final burst
      last_beats <= beats_t'(widx[burst_shift-1:0]) + beats_t'(1);
    end
  end

  // ************************************************************
  // checks
  // ************************************************************

  // pattern must fit in the memory
  a_wcnt_in_range: assert property (
    @(posedge axi_clk) disable iff (!axi_resetn)
    dma_acc |-> (wcnt < mem_words)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# compile the replay buffer testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dacfifo -Mdir obj_dir -f flist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_dacfifo)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

// File: tb/tb_clk_gen.sv
// clock and reset source for the replay buffer testbench
// 10 ns clock, reset held low for 5 cycles at start and again on rst_req

`timescale 1ns/1ps

module tb_clk_gen (
  output logic axi_clk,
  output logic axi_resetn,
  input  logic rst_req
);

  // reset cycles still to go
  logic [2:0] rst_left = 3'd5;

  initial begin
    axi_clk = 1'b0;
    forever #5 axi_clk = ~axi_clk;
  end

  // a request restarts the full 5-cycle reset
  always @(posedge axi_clk) begin
    if (rst_req) begin
      rst_left <= 3'd5;
    end else if (rst_left != 3'd0) begin
      rst_left <= rst_left - 3'd1;
    end
  end

  assign axi_resetn = (rst_left == 3'd0);

endmodule

// File: tb/tb_dacfifo.sv
// testbench for the DAC replay buffer
// loads random patterns over the dma stream, then checks the looping
// DAC stream against a replay model while dac_ready toggles at random
// runs a random length, a single burst and a partial final burst

`timescale 1ns/1ps

module tb_dacfifo
  import dacfifo_pkg::*;
();

  localparam int n_runs  = 3;
  localparam int n_loops = 6;

  logic  axi_clk;
  logic  axi_resetn;
  logic  rst_req;

  logic  dma_valid;
  word_t dma_data;
  logic  dma_last;
  logic  dma_ready;
  logic  dac_valid;
  word_t dac_data;
  logic  dac_ready;
  logic  dac_last;

  // pattern written this run, and beats seen on the DAC side
  word_t pattern [$];
  word_t got_data [$];
  logic  got_last [$];

  int    run_len [n_runs];
  bit    lens_ready;
  bit    loaded;
  int    ready_left;

  tb_clk_gen i_clk_gen (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .rst_req    (rst_req)
  );

  dacfifo_top DUT (
    .axi_clk    (axi_clk),
    .axi_resetn (axi_resetn),
    .dma_valid  (dma_valid),
    .dma_data   (dma_data),
    .dma_last   (dma_last),
    .dma_ready  (dma_ready),
    .dac_valid  (dac_valid),
    .dac_data   (dac_data),
    .dac_ready  (dac_ready),
    .dac_last   (dac_last)
  );

  // ************************************************************
  // compare tasks
  // ************************************************************

  task automatic fail_run();
    $display("Checks failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_data(input word_t got, input word_t exp, input int beat);
    if (got !== exp) begin
      $display("** Error at %0t: dac_data pattern beat %0d is %h, expected %h",
               $time, beat, got, exp);
      fail_run();
    end
  endtask

  task automatic check_last(input logic got, input logic exp, input int beat);
    if (got !== exp) begin
      $display("** Error at %0t: dac_last on pattern beat %0d is %b, expected %b",
               $time, beat, got, exp);
      fail_run();
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
      fail_run();
    end
  endtask

  // ************************************************************
  // stimulus
  // ************************************************************

  task automatic do_reset();
    rst_req <= 1'b1;
    @(posedge axi_clk);
    rst_req <= 1'b0;
    @(posedge axi_clk);
    while (!axi_resetn) @(posedge axi_clk);
  endtask

  // one beat per handshake, random idle cycles in between
  task automatic load_pattern(input int len);
    int gap;
    for (int i = 0; i < len; i++) begin
      gap = $urandom_range(2, 0);
      repeat (gap) begin
        dma_valid <= 1'b0;
        @(posedge axi_clk);
      end
      dma_valid <= 1'b1;
      dma_data  <= pattern[i];
      dma_last  <= (i == len - 1);
      @(posedge axi_clk);
      // beat taken on the edge that sees dma_ready high
      while (!dma_ready) @(posedge axi_clk);
    end
    dma_valid <= 1'b0;
    dma_last  <= 1'b0;
  endtask

  // load one pattern, then follow the replay for n_loops passes
  task automatic run_replay(input int len);
    int    idx;
    int    loops;
    int    final_base;
    word_t w;
    logic  l;
    pattern.delete();
    for (int i = 0; i < len; i++) begin
      pattern.push_back(word_t'($urandom()));
    end
    do_reset();
    got_data.delete();
    got_last.delete();
    loaded = 1'b0;
    check_flag("dma_ready after reset", dma_ready, 1'b1);
    load_pattern(len);
    loaded = 1'b1;
    @(posedge axi_clk);
    check_flag("dma_ready after the last dma beat", dma_ready, 1'b0);
    // first pattern beat of the final burst
    final_base = ((len - 1) / burst_len) * burst_len;
    idx   = 0;
    loops = 0;
    while (loops < n_loops) begin
      while (got_data.size() == 0) @(posedge axi_clk);
      w = got_data.pop_front();
      l = got_last.pop_front();
      check_data(w, pattern[idx], idx);
      check_last(l, (idx >= final_base), idx);
      idx++;
      // model wraps to pattern word zero
      if (idx == len) begin
        idx = 0;
        loops++;
      end
    end
  endtask

  // ************************************************************
  // main sequence
  // ************************************************************

  initial begin
    void'($urandom(32'hef6e_647f));
    rst_req    = 1'b0;
    dma_valid  = 1'b0;
    dma_data   = '0;
    dma_last   = 1'b0;
    loaded     = 1'b0;
    lens_ready = 1'b0;
    run_len[0] = $urandom_range(64, 1);
    // single burst
    run_len[1] = burst_len;
    // final burst only partly used
    do begin
      run_len[2] = $urandom_range(63, 1);
    end while (run_len[2] % burst_len == 0);
    lens_ready = 1'b1;
    for (int s = 0; s < n_runs; s++) begin
      $display("run %0d: pattern of %0d beats", s, run_len[s]);
      run_replay(run_len[s]);
    end
    $display("All checks passed");
    $finish;
  end

  // random stretches of dac_ready high and low
  initial begin
    dac_ready  = 1'b0;
    ready_left = 0;
    forever begin
      @(posedge axi_clk);
      if (ready_left == 0) begin
        dac_ready  <= ~dac_ready;
        ready_left <= $urandom_range(12, 1);
      end else begin
        ready_left <= ready_left - 1;
      end
    end
  end

  // every dac_valid cycle is one delivered beat
  always @(posedge axi_clk) begin
    if (axi_resetn && dac_valid) begin
      if (!loaded) begin
        $display("dac_valid came up before the pattern was fully loaded");
        fail_run();
      end else begin
        got_data.push_back(dac_data);
        got_last.push_back(dac_last);
      end
    end
  end

  // ************************************************************
  // watchdog
  // ************************************************************

  initial begin : watchdog
    int limit;
    wait (lens_ready);
    limit = 0;
    for (int s = 0; s < n_runs; s++) begin
      limit += (run_len[s] * 3 + 40) * n_loops * 20;
    end
    repeat (limit) @(posedge axi_clk);
    $display("timeout, the replay did not finish within %0d cycles", limit);
    $display("Checks failed");
    $fatal(1, "watchdog expired");
  end

endmodule
